// File: sim.f
hdl/ifu_pkg.sv
hdl/fetch_stage_if.sv
hdl/ifu_pc_gen.sv
hdl/ifu_l1i.sv
hdl/ifu_issue.sv
hdl/ifu_top.sv
verification/tb_mem_model.sv
verification/tb_ifu_top.sv

// File: Makefile
TOP = tb_ifu_top

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sim.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@! grep -q "Finished with errors" sim.log
	@grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module ifu_top -f sim.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: verification/tb_ifu_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ifu_top;

  localparam logic [31:0] BASE = 32'h8000_0000;
  localparam int NROWS = 11;
  localparam logic [1:0] RES_NONE = 2'd0;
  localparam logic [1:0] RES_RETIRE = 2'd1;
  localparam logic [1:0] RES_CHANGE = 2'd2;

  typedef struct {
    logic [31:0] pc;
    logic [31:0] inst;
    logic [1:0]  res;
    logic [31:0] target;
    int          hold;
    logic        refill;
  } row_t;

  row_t        rows [NROWS];
  logic        clk = 1'b0;
  logic        rst, ready, pc_change, pc_retire, arvalid, required, rvalid;
  logic        valid, spec, good_spec, bad_spec, refill_seen;
  logic [31:0] npc, pc_ret, araddr, rdata, inst, pc;
  logic        held_prev, good_prev, bad_prev, spec_prev;
  logic [31:0] prev_pc, prev_inst;
  int          errors = 0;
  int          held_errors = 0;
  int          good_count, bad_count, spec_count;

  always #4 clk = ~clk;

  ifu_top #(.RESET_PC(BASE)) u_dut (
    .clk(clk), .rst(rst), .araddr_o(araddr), .arvalid_o(arvalid), .required_o(required),
    .rdata_i(rdata), .rvalid_i(rvalid), .npc_i(npc), .pc_i(pc_ret),
    .pc_change_i(pc_change), .pc_retire_i(pc_retire), .ready_i(ready), .valid_o(valid),
    .inst_o(inst), .pc_o(pc), .speculation_o(spec), .good_speculation_o(good_spec),
    .bad_speculation_o(bad_spec)
  );

  tb_mem_model u_mem (
    .clk(clk), .rst(rst), .araddr_i(araddr), .arvalid_i(arvalid),
    .rdata_o(rdata), .rvalid_o(rvalid)
  );

  task automatic set_row(input int idx, input logic [31:0] ofs, input logic [31:0] word,
                         input logic [1:0] res, input logic [31:0] target, input int hold,
                         input logic refill);
    rows[idx] = '{BASE + ofs, word, res, target, hold, refill};
  endtask

  // jal stalls, branch speculates twice (good then bad), load, fence.i
  task automatic load_rows();
    set_row(0, 32'h00, 32'h0010_0093, RES_NONE, 32'h0, 0, 1'b1);
    set_row(1, 32'h04, 32'h0020_8113, RES_NONE, 32'h0, 0, 1'b0);
    set_row(2, 32'h08, 32'h0031_0193, RES_NONE, 32'h0, 0, 1'b1);
    set_row(3, 32'h0c, 32'h0340_006f, RES_CHANGE, BASE + 32'h40, 5, 1'b0);
    set_row(4, 32'h40, 32'h0042_0213, RES_NONE, 32'h0, 0, 1'b1);
    set_row(5, 32'h44, 32'hfe00_0ee3, RES_CHANGE, BASE + 32'h40, 0, 1'b0);
    set_row(6, 32'h40, 32'h0042_0213, RES_NONE, 32'h0, 0, 1'b0);
    set_row(7, 32'h44, 32'hfe00_0ee3, RES_RETIRE, 32'h0, 0, 1'b0);
    set_row(8, 32'h48, 32'h0000_a283, RES_RETIRE, 32'h0, 5, 1'b1);
    set_row(9, 32'h4c, 32'h0000_100f, RES_CHANGE, BASE + 32'h40, 5, 1'b0);
    set_row(10, 32'h40, 32'h0042_0213, RES_NONE, 32'h0, 0, 1'b1);
  endtask

  initial begin
    logic got;
    int   i;
    void'($urandom(53464));
    rst = 1'b1;
    ready = 1'b0;
    pc_change = 1'b0;
    pc_retire = 1'b0;
    npc = '0;
    pc_ret = '0;
    refill_seen = 1'b0;
    load_rows();
    for (i = 0; i < NROWS; i++) begin
      u_mem.prog[rows[i].pc] = rows[i].inst;
    end
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    for (i = 0; i < NROWS; i++) begin
      got = 1'b0;
      while (!got) begin
        @(posedge clk);
        pc_change <= 1'b0;
        pc_retire <= 1'b0;
        if (required) refill_seen = 1'b1;
        got = valid && ready;
        ready <= ($urandom_range(0, 3) != 0);
      end
      assert (pc == rows[i].pc) else begin
        errors++;
        $display("Fail pc_o: got %h, expected %h", pc, rows[i].pc);
      end
      assert (inst == rows[i].inst) else begin
        errors++;
        $display("Fail inst_o: got %h, expected %h", inst, rows[i].inst);
      end
      assert (refill_seen == rows[i].refill) else begin
        errors++;
        $display("Fail required_o: got %h, expected %h", refill_seen, rows[i].refill);
      end
      repeat (rows[i].hold) begin
        @(posedge clk);
        pc_change <= 1'b0;
        pc_retire <= 1'b0;
        ready <= ($urandom_range(0, 3) != 0);
        assert (!valid) else begin
          errors++;
          $display("Fail valid_o: got %h, expected %h", valid, 1'b0);
        end
      end
      if (rows[i].res == RES_CHANGE) begin
        pc_change <= 1'b1;
        npc <= rows[i].target;
      end else if (rows[i].res == RES_RETIRE) begin
        pc_retire <= 1'b1;
        pc_ret <= rows[i].pc;
      end
      refill_seen = 1'b0;
    end
    // two speculative branches, one confirmed and one wrong
    assert (spec_count == 2 && good_count == 1 && bad_count == 1) else begin
      errors++;
      $display("Speculation pulses wrong: %0d speculated, %0d good, %0d bad",
               spec_count, good_count, bad_count);
    end
    $display("Errors: table %0d, held slot %0d", errors, held_errors);
    if (errors == 0 && held_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // held slot stability and speculation outcome counting
  always @(posedge clk) begin
    if (rst) begin
      held_prev <= 1'b0;
      good_prev <= 1'b0;
      bad_prev <= 1'b0;
      spec_prev <= 1'b0;
      good_count <= 0;
      bad_count <= 0;
      spec_count <= 0;
    end else begin
      if (held_prev && !bad_spec) begin
        assert (valid && pc == prev_pc && inst == prev_inst) else begin
          held_errors++;
          $display("Fail held pc_o/inst_o: got %h/%h, expected %h/%h",
                   pc, inst, prev_pc, prev_inst);
        end
      end
      held_prev <= valid && !ready;
      prev_pc <= pc;
      prev_inst <= inst;
      good_prev <= good_spec;
      bad_prev <= bad_spec;
      spec_prev <= spec;
      if (good_spec && !good_prev) good_count <= good_count + 1;
      if (bad_spec && !bad_prev) bad_count <= bad_count + 1;
      if (spec && !spec_prev) spec_count <= spec_count + 1;
    end
  end

  initial begin
    repeat (NROWS * 400) @(posedge clk);
    $display("Timeout after %0d cycles without reaching the end of the table", NROWS * 400);
    $display("Errors: table %0d, held slot %0d", errors, held_errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model (
  input  wire         clk,
  input  wire         rst,
  input  wire [31:0]  araddr_i,
  input  wire         arvalid_i,
  output logic [31:0] rdata_o,
  output logic        rvalid_o
);

  // program words, written by the testbench before reset ends
  logic [31:0] prog [logic [31:0]];
  logic [31:0] addr_q;
  logic [1:0]  delay_q;
  logic [2:0]  lat;
  logic        pending_q;

  // unwritten words read as addi with an address-dependent immediate
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    if (prog.exists(addr)) begin
      return prog[addr];
    end
    return {addr[31:7] ^ addr[24:0], 7'h13};
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      pending_q <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
    end else begin
      rvalid_o <= 1'b0;
      if (arvalid_i) begin
        // 1 to 4 cycles latency
        lat = 3'($urandom_range(1, 4));
        if (lat == 3'd1) begin
          rvalid_o <= 1'b1;
          rdata_o  <= word_at(araddr_i);
        end else begin
          pending_q <= 1'b1;
          addr_q    <= araddr_i;
          delay_q   <= 2'(lat - 3'd2);
        end
      end else if (pending_q) begin
        if (delay_q == 2'd0) begin
          pending_q <= 1'b0;
          rvalid_o  <= 1'b1;
          rdata_o   <= word_at(addr_q);
        end else begin
          delay_q <= delay_q - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/ifu_top.sv
`timescale 1ns/100ps
`default_nettype none

module ifu_top #(
  parameter logic [ifu_pkg::XLEN-1:0] RESET_PC = 32'h8000_0000
) (
  input  wire                          clk,
  input  wire                          rst,
  output logic [ifu_pkg::XLEN-1:0]     araddr_o,
  output logic                         arvalid_o,
  output logic                         required_o,
  input  wire [ifu_pkg::XLEN-1:0]      rdata_i,
  input  wire                          rvalid_i,
  input  wire [ifu_pkg::XLEN-1:0]      npc_i,
  input  wire [ifu_pkg::XLEN-1:0]      pc_i,
  input  wire                          pc_change_i,
  input  wire                          pc_retire_i,
  input  wire                          ready_i,
  output logic                         valid_o,
  output logic [ifu_pkg::XLEN-1:0]     inst_o,
  output logic [ifu_pkg::XLEN-1:0]     pc_o,
  output logic                         speculation_o,
  output logic                         good_speculation_o,
  output logic                         bad_speculation_o
);

  ifu_pkg::inst_class_e  fire_class;
  logic                  fire;
  logic                  fence_pulse;
  logic                  stall;
  logic                  flush;

  fetch_stage_if fetch_pc ();
  fetch_stage_if fetch_iss ();

  // issue stage sees the same slot
  assign fetch_iss.pc   = fetch_pc.pc;
  assign fetch_iss.inst = fetch_pc.inst;
  assign fetch_iss.hit  = fetch_pc.hit;
  assign fetch_iss.busy = fetch_pc.busy;

  ifu_pc_gen #(
    .RESET_PC (RESET_PC)
  ) u_pc_gen (
    .clk                (clk),
    .rst                (rst),
    .fetch              (fetch_pc.pc_mp),
    .fire_i             (fire),
    .fire_class_i       (fire_class),
    .npc_i              (npc_i),
    .pc_i               (pc_i),
    .pc_change_i        (pc_change_i),
    .pc_retire_i        (pc_retire_i),
    .stall_o            (stall),
    .flush_o            (flush),
    .speculation_o      (speculation_o),
    .good_speculation_o (good_speculation_o),
    .bad_speculation_o  (bad_speculation_o)
  );

  ifu_l1i u_l1i (
    .clk          (clk),
    .rst          (rst),
    .fetch        (fetch_pc.cache_mp),
    .invalidate_i (fence_pulse),
    .araddr_o     (araddr_o),
    .arvalid_o    (arvalid_o),
    .required_o   (required_o),
    .rdata_i      (rdata_i),
    .rvalid_i     (rvalid_i)
  );

  ifu_issue u_issue (
    .clk          (clk),
    .rst          (rst),
    .fetch        (fetch_iss.issue_mp),
    .stall_i      (stall),
    .flush_i      (flush),
    .ready_i      (ready_i),
    .valid_o      (valid_o),
    .inst_o       (inst_o),
    .pc_o         (pc_o),
    .fire_o       (fire),
    .fire_class_o (fire_class),
    .fence_o      (fence_pulse)
  );

endmodule

`default_nettype wire

// File: hdl/ifu_issue.sv
`timescale 1ns/100ps
`default_nettype none

module ifu_issue (
  input  wire                          clk,
  input  wire                          rst,
  fetch_stage_if.issue_mp              fetch,
  input  wire                          stall_i,
  input  wire                          flush_i,
  input  wire                          ready_i,
  output logic                         valid_o,
  output logic [ifu_pkg::XLEN-1:0]     inst_o,
  output logic [ifu_pkg::XLEN-1:0]     pc_o,
  output logic                         fire_o,
  output ifu_pkg::inst_class_e         fire_class_o,
  output logic                         fence_o
);

  ifu_pkg::inst_class_e        out_class;
  logic                        held_q;
  logic [ifu_pkg::XLEN-1:0]    held_pc_q;
  logic [ifu_pkg::XLEN-1:0]    held_inst_q;

  // a shown slot stays put until taken or flushed
  assign valid_o = !flush_i && (held_q || (fetch.hit && !stall_i));
  assign pc_o    = held_q ? held_pc_q : fetch.pc.raw;
  assign inst_o  = held_q ? held_inst_q : fetch.inst;

  assign out_class    = ifu_pkg::classify(inst_o);
  assign fire_o       = valid_o && ready_i;
  assign fire_class_o = out_class;
  assign fence_o      = fire_o && (out_class == ifu_pkg::CLS_FENCE);

  always_ff @(posedge clk) begin
    if (rst) begin
      held_q <= 1'b0;
    end else if (fire_o || flush_i) begin
      held_q <= 1'b0;
    end else if (valid_o) begin
      held_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_o && !held_q) begin
      held_pc_q   <= pc_o;
      held_inst_q <= inst_o;
    end
  end

endmodule

`default_nettype wire

// File: hdl/ifu_l1i.sv
`timescale 1ns/100ps
`default_nettype none

module ifu_l1i (
  input  wire                        clk,
  input  wire                        rst,
  fetch_stage_if.cache_mp            fetch,
  input  wire                        invalidate_i,
  output logic [ifu_pkg::XLEN-1:0]   araddr_o,
  output logic                       arvalid_o,
  output logic                       required_o,
  input  wire [ifu_pkg::XLEN-1:0]    rdata_i,
  input  wire                        rvalid_i
);

  localparam int LINES = 2 ** ifu_pkg::L1I_IDX_W;
  localparam int WORDS = 2 ** ifu_pkg::L1I_OFS_W;

  typedef enum logic [2:0] {
    S_IDLE,
    S_WAIT_EVEN,
    S_REQ_ODD,
    S_WAIT_ODD,
    S_DONE
  } l1i_state_e;

  l1i_state_e                       state_q;
  ifu_pkg::l1i_addr_u               refill_q;
  ifu_pkg::l1i_addr_u               req_addr;
  logic [ifu_pkg::XLEN-1:0]         data_q [LINES][WORDS];
  logic [ifu_pkg::L1I_TAG_W-1:0]    tag_q [LINES];
  logic [LINES-1:0]                 valid_q;
  logic                             line_ok;
  logic                             lookup;
  logic                             miss_req;
  logic                             same_line;
  logic                             fwd_odd;

  assign line_ok = valid_q[fetch.pc.fields.idx] &&
                   tag_q[fetch.pc.fields.idx] == fetch.pc.fields.tag;
  assign lookup  = (state_q == S_IDLE) || (state_q == S_DONE);

  assign fetch.hit  = (lookup && line_ok) || fwd_odd;
  assign fetch.busy = (state_q != S_IDLE);

  assign miss_req   = (state_q == S_IDLE) && !line_ok;
  assign arvalid_o  = miss_req || (state_q == S_REQ_ODD);
  assign required_o = miss_req || (state_q inside {S_WAIT_EVEN, S_REQ_ODD, S_WAIT_ODD});

  // first request from the live pc, the odd one from the latched line
  always_comb begin
    req_addr = (state_q == S_IDLE) ? fetch.pc : refill_q;
    req_addr.fields.ofs = (state_q == S_REQ_ODD) ? '1 : '0;
    req_addr.fields.byte_ofs = 2'b00;
  end

  assign araddr_o = req_addr.raw;

  // odd word is usable in its arrival cycle
  assign same_line = refill_q.fields.tag == fetch.pc.fields.tag &&
                     refill_q.fields.idx == fetch.pc.fields.idx;
  assign fwd_odd   = (state_q == S_WAIT_ODD) && rvalid_i && same_line &&
                     fetch.pc.fields.ofs == '1;

  assign fetch.inst = fwd_odd ? rdata_i :
                      data_q[fetch.pc.fields.idx][fetch.pc.fields.ofs];

  always_ff @(posedge clk) begin
    if (rst) begin
      // one settle cycle before the first request
      state_q <= S_DONE;
      valid_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (miss_req) begin
            state_q <= S_WAIT_EVEN;
          end
        end
        S_WAIT_EVEN: begin
          if (rvalid_i) begin
            state_q <= S_REQ_ODD;
          end
        end
        S_REQ_ODD: state_q <= S_WAIT_ODD;
        S_WAIT_ODD: begin
          if (rvalid_i) begin
            state_q <= S_DONE;
            valid_q[refill_q.fields.idx] <= 1'b1;
          end
        end
        default: state_q <= S_IDLE;
      endcase
      if (invalidate_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (miss_req) begin
      refill_q <= fetch.pc;
    end
    if (state_q == S_WAIT_EVEN && rvalid_i) begin
      data_q[refill_q.fields.idx][0] <= rdata_i;
    end
    if (state_q == S_WAIT_ODD && rvalid_i) begin
      data_q[refill_q.fields.idx][1] <= rdata_i;
      tag_q[refill_q.fields.idx]     <= refill_q.fields.tag;
    end
  end

endmodule

`default_nettype wire

// File: hdl/ifu_pc_gen.sv
`timescale 1ns/100ps
`default_nettype none

module ifu_pc_gen #(
  parameter logic [ifu_pkg::XLEN-1:0] RESET_PC = 32'h8000_0000
) (
  input  wire                          clk,
  input  wire                          rst,
  fetch_stage_if.pc_mp                 fetch,
  input  wire                          fire_i,
  input  wire ifu_pkg::inst_class_e    fire_class_i,
  input  wire [ifu_pkg::XLEN-1:0]      npc_i,
  input  wire [ifu_pkg::XLEN-1:0]      pc_i,
  input  wire                          pc_change_i,
  input  wire                          pc_retire_i,
  output logic                         stall_o,
  output logic                         flush_o,
  output logic                         speculation_o,
  output logic                         good_speculation_o,
  output logic                         bad_speculation_o
);

  ifu_pkg::l1i_addr_u          pc_q;
  ifu_pkg::inst_class_e        cur_class;
  logic [ifu_pkg::XLEN-1:0]    pc_plus4;
  logic [ifu_pkg::XLEN-1:0]    btb_q;
  logic [ifu_pkg::XLEN-1:0]    spec_target_q;
  logic [ifu_pkg::XLEN-1:0]    spec_fall_q;
  logic [ifu_pkg::XLEN-1:0]    redirect_q;
  logic                        btb_valid_q;
  logic                        hazard_q;
  logic                        spec_q;
  logic                        cond_q;
  logic                        good_q;
  logic                        bad_q;
  logic                        resolve;
  logic                        match;
  logic                        mismatch;
  logic                        mem_wait;

  assign pc_plus4 = pc_q.raw + 32'd4;
  assign resolve  = pc_change_i || pc_retire_i;

  assign match = spec_q && ((pc_change_i && npc_i == spec_target_q) ||
                            (pc_retire_i && pc_i + 32'd4 == spec_target_q));
  assign mismatch = spec_q && ((pc_change_i && npc_i != spec_target_q) ||
                               (pc_retire_i && pc_i + 32'd4 != spec_target_q));

  // memory ops wait for the branch in flight
  assign cur_class = ifu_pkg::classify(fetch.inst);
  assign mem_wait  = spec_q && (cur_class == ifu_pkg::CLS_LOAD ||
                                cur_class == ifu_pkg::CLS_STORE);

  assign fetch.pc           = pc_q;
  assign stall_o            = hazard_q || mem_wait;
  assign bad_speculation_o  = bad_q || mismatch;
  assign flush_o            = bad_speculation_o;
  assign speculation_o      = spec_q;
  assign good_speculation_o = good_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q.raw    <= RESET_PC;
      btb_valid_q <= 1'b0;
      hazard_q    <= 1'b0;
      spec_q      <= 1'b0;
      good_q      <= 1'b0;
      bad_q       <= 1'b0;
    end else begin
      good_q <= match;
      if (pc_change_i) begin
        btb_q       <= npc_i;
        btb_valid_q <= 1'b1;
      end
      if (bad_q) begin
        // redirect only after any refill drains
        if (!fetch.busy) begin
          bad_q    <= 1'b0;
          hazard_q <= 1'b0;
          pc_q.raw <= redirect_q;
        end
      end else if (mismatch) begin
        bad_q      <= 1'b1;
        spec_q     <= 1'b0;
        // not-taken cond branch falls through
        redirect_q <= (cond_q && pc_retire_i) ? spec_fall_q : npc_i;
      end else begin
        if (match) begin
          spec_q <= 1'b0;
        end
        if (hazard_q && resolve && !spec_q) begin
          hazard_q <= 1'b0;
          pc_q.raw <= pc_change_i ? npc_i : pc_plus4;
        end else if (fire_i) begin
          case (fire_class_i)
            ifu_pkg::CLS_PLAIN: pc_q.raw <= pc_plus4;
            ifu_pkg::CLS_BRANCH, ifu_pkg::CLS_COND_BRANCH: begin
              if (btb_valid_q && !spec_q) begin
                pc_q.raw      <= btb_q;
                spec_target_q <= btb_q;
                spec_fall_q   <= pc_plus4;
                spec_q        <= 1'b1;
                cond_q        <= (fire_class_i == ifu_pkg::CLS_COND_BRANCH);
              end else begin
                hazard_q <= 1'b1;
              end
            end
            default: hazard_q <= 1'b1;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/fetch_stage_if.sv
`timescale 1ns/100ps
`default_nettype none

interface fetch_stage_if;

  ifu_pkg::l1i_addr_u          pc;
  logic [ifu_pkg::XLEN-1:0]    inst;
  logic                        hit;
  // refill or settle cycle in progress
  logic                        busy;

  modport pc_mp (
    output pc,
    input  inst,
    input  busy
  );

  modport cache_mp (
    input  pc,
    output inst,
    output hit,
    output busy
  );

  modport issue_mp (
    input pc,
    input inst,
    input hit,
    input busy
  );

endinterface

`default_nettype wire

// File: hdl/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

  localparam int XLEN = 32;

  // four lines of two words
  localparam int L1I_IDX_W = 2;
  localparam int L1I_OFS_W = 1;
  localparam int L1I_TAG_W = XLEN - L1I_IDX_W - L1I_OFS_W - 2;

  typedef struct packed {
    logic [L1I_TAG_W-1:0] tag;
    logic [L1I_IDX_W-1:0] idx;
    logic [L1I_OFS_W-1:0] ofs;
    logic [1:0]           byte_ofs;
  } l1i_addr_fields_t;

  typedef union packed {
    logic [XLEN-1:0]  raw;
    l1i_addr_fields_t fields;
  } l1i_addr_u;

  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;

  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;

  typedef enum logic [2:0] {
    CLS_PLAIN,
    CLS_BRANCH,
    CLS_COND_BRANCH,
    CLS_LOAD,
    CLS_STORE,
    CLS_FENCE
  } inst_class_e;

  // system ops redirect like jumps
  function automatic inst_class_e classify(input logic [XLEN-1:0] inst);
    inst_class_e cls;
    case (inst[6:0])
      OP_JAL, OP_JALR, OP_SYSTEM: cls = CLS_BRANCH;
      OP_BRANCH:                  cls = CLS_COND_BRANCH;
      OP_LOAD:                    cls = CLS_LOAD;
      OP_STORE:                   cls = CLS_STORE;
      default:                    cls = CLS_PLAIN;
    endcase
    if (inst == INST_FENCE_I) begin
      cls = CLS_FENCE;
    end
    return cls;
  endfunction

endpackage

`default_nettype wire
